// File: common/decode_pkg.sv
package decode_pkg;

  localparam int data_width     = 16;
  localparam int reg_addr_width = 3;

  // jump opcodes share the top bits so the low two bits select the condition
  typedef enum logic [4:0] {
    op_nop  = 5'h00,
    op_mov  = 5'h01,
    op_add  = 5'h02,
    op_sub  = 5'h03,
    op_and  = 5'h04,
    op_or   = 5'h05,
    op_not  = 5'h06,
    op_shl  = 5'h07,
    op_shr  = 5'h08,
    op_ldm  = 5'h09,
    op_ldd  = 5'h0a,
    op_std  = 5'h0b,
    op_push = 5'h0c,
    op_pop  = 5'h0d,
    op_in   = 5'h0e,
    op_out  = 5'h0f,
    op_jz   = 5'h10,
    op_jn   = 5'h11,
    op_jc   = 5'h12,
    op_jmp  = 5'h13,
    op_call = 5'h14,
    op_ret  = 5'h15,
    op_rti  = 5'h16
  } opcode_t;

  typedef logic [4:0] alu_op_t;  // same value as the opcode for alu operations, else 0

  typedef struct packed {
    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [4:0]                unused;
  } instr_reg_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rdst;
    logic [7:0]                imm;
  } instr_imm_t;

  typedef union packed {
    instr_reg_t reg_form;
    instr_imm_t imm_form;
  } instr_u;

endpackage

// File: common/reg_read_if.sv
`timescale 1ns/10ps

// two read ports with no handshake, data is valid in the same cycle
interface reg_read_if;

  logic [decode_pkg::reg_addr_width-1:0] addr1;
  logic [decode_pkg::reg_addr_width-1:0] addr2;
  logic [decode_pkg::data_width-1:0]     data1;
  logic [decode_pkg::data_width-1:0]     data2;

  modport requester (
    output addr1,
    output addr2,
    input  data1,
    input  data2
  );

  modport responder (
    input  addr1,
    input  addr2,
    output data1,
    output data2
  );

endinterface

// File: control_unit/control_unit.sv
`timescale 1ns/10ps

module control_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  decode_pkg::opcode_t opcode,
  input  logic                interrupt,
  input  logic                load_use,
  input  logic                taken,
  output decode_pkg::alu_op_t alu_op,
  output logic [1:0]          alu_src,
  output logic                reg_write,
  output logic                mem_read,
  output logic                mem_write,
  output logic                ldm,
  output logic                mem_to_reg,
  output logic                branch,
  output logic [1:0]          pc_sel,
  output logic                call,
  output logic                ret,
  output logic                rti,
  output logic                stack,
  output logic                pop_pc1,
  output logic                pop_pc2,
  output logic                pop_ccr,
  output logic [1:0]          mem_data_sel,
  output logic                port_read,
  output logic                port_write,
  output logic                freeze,
  output logic                fetch_pc_enable
);

  // states hold the remaining cycles of a stack sequence
  localparam logic [2:0] st_idle    = 3'd0;
  localparam logic [2:0] st_int_ccr = 3'd1;
  localparam logic [2:0] st_ret_pc2 = 3'd2;
  localparam logic [2:0] st_rti_pc2 = 3'd3;
  localparam logic [2:0] st_rti_ccr = 3'd4;

  logic [2:0] state;
  logic [2:0] state_next;
  logic       pc_load;  // unconditional jump, JMP or CALL
  logic       pc_cond;  // conditional jump, follows taken

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    alu_op          = '0;
    alu_src         = 2'b00;
    reg_write       = 1'b0;
    mem_read        = 1'b0;
    mem_write       = 1'b0;
    ldm             = 1'b0;
    mem_to_reg      = 1'b0;
    branch          = 1'b0;
    call            = 1'b0;
    ret             = 1'b0;
    rti             = 1'b0;
    stack           = 1'b0;
    pop_pc1         = 1'b0;
    pop_pc2         = 1'b0;
    pop_ccr         = 1'b0;
    mem_data_sel    = 2'b00;
    port_read       = 1'b0;
    port_write      = 1'b0;
    freeze          = 1'b0;
    fetch_pc_enable = 1'b1;
    pc_load         = 1'b0;
    pc_cond         = 1'b0;
    state_next      = st_idle;

    case (state)
      st_int_ccr: begin
        stack        = 1'b1;
        mem_write    = 1'b1;
        mem_data_sel = 2'd2;  // second push carries the flags
      end
      st_ret_pc2: begin
        stack    = 1'b1;
        mem_read = 1'b1;
        ret      = 1'b1;
        pop_pc2  = 1'b1;
      end
      st_rti_pc2: begin
        stack           = 1'b1;
        mem_read        = 1'b1;
        rti             = 1'b1;
        pop_pc2         = 1'b1;
        freeze          = 1'b1;
        fetch_pc_enable = 1'b0;
        state_next      = st_rti_ccr;
      end
      st_rti_ccr: begin
        stack    = 1'b1;
        mem_read = 1'b1;
        rti      = 1'b1;
        pop_ccr  = 1'b1;
      end
      default: begin
        if (load_use) begin
          fetch_pc_enable = 1'b0;  // bubble, the control word stays all zero
        end else if (interrupt) begin
          stack           = 1'b1;
          mem_write       = 1'b1;
          call            = 1'b1;
          freeze          = 1'b1;
          fetch_pc_enable = 1'b0;
          state_next      = st_int_ccr;
        end else begin
          case (opcode)
            decode_pkg::op_mov, decode_pkg::op_add, decode_pkg::op_sub,
            decode_pkg::op_and, decode_pkg::op_or, decode_pkg::op_not: begin
              alu_op    = opcode;
              reg_write = 1'b1;
            end
            decode_pkg::op_shl, decode_pkg::op_shr: begin
              alu_op    = opcode;
              alu_src   = 2'b01;  // shift amount comes from the immediate
              reg_write = 1'b1;
            end
            decode_pkg::op_ldm: begin
              alu_src   = 2'b01;
              ldm       = 1'b1;
              reg_write = 1'b1;
            end
            decode_pkg::op_ldd: begin
              mem_read   = 1'b1;
              mem_to_reg = 1'b1;
              reg_write  = 1'b1;
            end
            decode_pkg::op_std: begin
              mem_write = 1'b1;
            end
            decode_pkg::op_push: begin
              mem_write = 1'b1;
              stack     = 1'b1;
            end
            decode_pkg::op_pop: begin
              mem_read   = 1'b1;
              stack      = 1'b1;
              mem_to_reg = 1'b1;
              reg_write  = 1'b1;
            end
            decode_pkg::op_in: begin
              port_read = 1'b1;
              reg_write = 1'b1;
            end
            decode_pkg::op_out: begin
              port_write = 1'b1;
            end
            decode_pkg::op_jz, decode_pkg::op_jn, decode_pkg::op_jc: begin
              branch  = 1'b1;
              pc_cond = 1'b1;
            end
            decode_pkg::op_jmp: begin
              branch  = 1'b1;
              pc_load = 1'b1;
            end
            decode_pkg::op_call: begin
              branch  = 1'b1;
              pc_load = 1'b1;
              call    = 1'b1;
              stack   = 1'b1;
            end
            decode_pkg::op_ret: begin
              stack           = 1'b1;
              mem_read        = 1'b1;
              ret             = 1'b1;
              pop_pc1         = 1'b1;
              freeze          = 1'b1;
              fetch_pc_enable = 1'b0;
              state_next      = st_ret_pc2;
            end
            decode_pkg::op_rti: begin
              stack           = 1'b1;
              mem_read        = 1'b1;
              rti             = 1'b1;
              pop_pc1         = 1'b1;
              freeze          = 1'b1;
              fetch_pc_enable = 1'b0;
              state_next      = st_rti_pc2;
            end
            default: begin
              // nop and unused codes leave the word cleared
            end
          endcase
        end
      end
    endcase
  end

  // kept apart from the decode block since taken itself depends on branch
  assign pc_sel = {1'b0, pc_load | (pc_cond & taken)};

endmodule

// File: register_file/register_file.sv
`timescale 1ns/10ps

module register_file #(
  parameter int reg_count = 8
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic                                  write_enable,
  input  logic [decode_pkg::reg_addr_width-1:0] write_addr,
  input  logic [decode_pkg::data_width-1:0]     write_data,
  reg_read_if.responder                         rd
);

  logic [decode_pkg::data_width-1:0] regs [reg_count];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_addr] <= write_data;
    end
  end

  // no bypass, a read in the write cycle still sees the old word
  assign rd.data1 = regs[rd.addr1];
  assign rd.data2 = regs[rd.addr2];

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
top=tb_instruction_decode

verilator --binary --timing -f verilog.f --top-module "$top" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log_file"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

// File: source/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
  input  logic                              branch,
  input  logic [1:0]                        jtype,
  input  logic [2:0]                        ccr,  // bit 0 zero, bit 1 negative, bit 2 carry
  input  logic [decode_pkg::data_width-1:0] rdst,
  output logic                              taken,
  output logic [31:0]                       jump_target
);

  logic cond_met;

  always_comb begin
    case (jtype)
      2'b00: begin
        cond_met = ccr[0];
      end
      2'b01: begin
        cond_met = ccr[1];
      end
      2'b10: begin
        cond_met = ccr[2];
      end
      default: begin
        cond_met = 1'b1;  // JMP ignores the flags
      end
    endcase
  end

  assign taken = branch & cond_met;

  // the target register holds the address, upper half of the PC is zero
  assign jump_target = {{(32 - decode_pkg::data_width){1'b0}}, rdst};

endmodule

// File: source/instruction_decode.sv
`timescale 1ns/10ps

module instruction_decode #(
  parameter int reg_count = 8
) (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  logic [15:0]                           instruction,
  input  logic                                  interrupt,
  input  logic                                  load_use,
  input  logic [2:0]                            ccr,
  input  logic                                  wb_enable,
  input  logic [decode_pkg::reg_addr_width-1:0] wb_addr,
  input  logic [decode_pkg::data_width-1:0]     wb_data,
  output logic [decode_pkg::data_width-1:0]     op1,
  output logic [decode_pkg::data_width-1:0]     op2_reg,
  output logic [decode_pkg::data_width-1:0]     op2_imm,
  output logic [decode_pkg::reg_addr_width-1:0] dest_addr,
  output logic [7:0]                            shift_amount,
  output logic [31:0]                           jump_target,
  output decode_pkg::alu_op_t                   alu_op,
  output logic [1:0]                            alu_src,
  output logic                                  reg_write,
  output logic                                  mem_read,
  output logic                                  mem_write,
  output logic                                  ldm,
  output logic                                  mem_to_reg,
  output logic                                  branch,
  output logic [1:0]                            pc_sel,
  output logic                                  call,
  output logic                                  ret,
  output logic                                  rti,
  output logic                                  stack,
  output logic                                  pop_pc1,
  output logic                                  pop_pc2,
  output logic                                  pop_ccr,
  output logic [1:0]                            mem_data_sel,
  output logic                                  port_read,
  output logic                                  port_write,
  output logic                                  freeze,
  output logic                                  fetch_pc_enable
);

  decode_pkg::instr_u instr;
  logic               taken;

  reg_read_if rd_port ();

  assign instr = instruction;

  assign rd_port.addr1 = instr.reg_form.rs1;
  assign rd_port.addr2 = instr.reg_form.rs2;
  assign op1           = rd_port.data1;
  assign op2_reg       = rd_port.data2;

  assign op2_imm      = {{(decode_pkg::data_width - 8){1'b0}}, instr.imm_form.imm};
  assign shift_amount = instr.imm_form.imm;
  assign dest_addr    = alu_src[0] ? instr.imm_form.rdst : instr.reg_form.rs2;  // immediate forms write rdst

  register_file #(
    .reg_count (reg_count)
  ) u_register_file (
    .clk          (clk),
    .arst_n       (arst_n),
    .write_enable (wb_enable),
    .write_addr   (wb_addr),
    .write_data   (wb_data),
    .rd           (rd_port)
  );

  control_unit u_control_unit (
    .clk             (clk),
    .arst_n          (arst_n),
    .opcode          (instr.reg_form.opcode),
    .interrupt       (interrupt),
    .load_use        (load_use),
    .taken           (taken),
    .alu_op          (alu_op),
    .alu_src         (alu_src),
    .reg_write       (reg_write),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .ldm             (ldm),
    .mem_to_reg      (mem_to_reg),
    .branch          (branch),
    .pc_sel          (pc_sel),
    .call            (call),
    .ret             (ret),
    .rti             (rti),
    .stack           (stack),
    .pop_pc1         (pop_pc1),
    .pop_pc2         (pop_pc2),
    .pop_ccr         (pop_ccr),
    .mem_data_sel    (mem_data_sel),
    .port_read       (port_read),
    .port_write      (port_write),
    .freeze          (freeze),
    .fetch_pc_enable (fetch_pc_enable)
  );

  branch_unit u_branch_unit (
    .branch      (branch),
    .jtype       (instr.reg_form.opcode[1:0]),
    .ccr         (ccr),
    .rdst        (op2_reg),
    .taken       (taken),
    .jump_target (jump_target)
  );

endmodule

// File: verification/tb_instruction_decode.sv
`timescale 1ns/10ps

module tb_instruction_decode;

  localparam int check_delay = 15;  // falling edge plus 15 ns is 5 ns before the rising edge
  localparam int seq_timeout = 8;

  // control word packed msb first as alu_op, alu_src, reg_write, mem_read, mem_write, ldm,
  // mem_to_reg, branch, pc_sel, call, ret, rti, stack, pop_pc1, pop_pc2, pop_ccr,
  // mem_data_sel, port_read, port_write, freeze and fetch_pc_enable
  localparam logic [27:0] src_imm  = 28'd1 << 21;
  localparam logic [27:0] reg_wr   = 28'd1 << 20;
  localparam logic [27:0] mem_rd   = 28'd1 << 19;
  localparam logic [27:0] mem_wr   = 28'd1 << 18;
  localparam logic [27:0] ldm_bit  = 28'd1 << 17;
  localparam logic [27:0] to_reg   = 28'd1 << 16;
  localparam logic [27:0] br_bit   = 28'd1 << 15;
  localparam logic [27:0] pc_jump  = 28'd1 << 13;
  localparam logic [27:0] call_bit = 28'd1 << 12;
  localparam logic [27:0] ret_bit  = 28'd1 << 11;
  localparam logic [27:0] rti_bit  = 28'd1 << 10;
  localparam logic [27:0] stk_bit  = 28'd1 << 9;
  localparam logic [27:0] pc1_bit  = 28'd1 << 8;
  localparam logic [27:0] pc2_bit  = 28'd1 << 7;
  localparam logic [27:0] ccr_bit  = 28'd1 << 6;
  localparam logic [27:0] sel_ccr  = 28'd2 << 4;
  localparam logic [27:0] prt_rd   = 28'd1 << 3;
  localparam logic [27:0] prt_wr   = 28'd1 << 2;
  localparam logic [27:0] frz_bit  = 28'd1 << 1;
  localparam logic [27:0] fetch_en = 28'd1;

  typedef struct {
    string       name;
    logic [15:0] instr;
    logic        intr;
    logic        lu;
    logic [2:0]  ccr;
    logic [27:0] exp;
  } row_t;

  logic clk;
  logic arst_n;
  logic [15:0] instruction;
  logic interrupt;
  logic load_use;
  logic [2:0] ccr;
  logic wb_enable;
  logic [2:0] wb_addr;
  logic [15:0] wb_data;
  logic [15:0] op1;
  logic [15:0] op2_reg;
  logic [15:0] op2_imm;
  logic [2:0] dest_addr;
  logic [7:0] shift_amount;
  logic [31:0] jump_target;
  decode_pkg::alu_op_t alu_op;
  logic [1:0] alu_src;
  logic reg_write;
  logic mem_read;
  logic mem_write;
  logic ldm;
  logic mem_to_reg;
  logic branch;
  logic [1:0] pc_sel;
  logic call;
  logic ret;
  logic rti;
  logic stack;
  logic pop_pc1;
  logic pop_pc2;
  logic pop_ccr;
  logic [1:0] mem_data_sel;
  logic port_read;
  logic port_write;
  logic freeze;
  logic fetch_pc_enable;

  logic [15:0] model [8];  // expected register contents
  row_t        rows[$];
  logic [27:0] seq_exp[$];

  instruction_decode #(
    .reg_count (8)
  ) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [15:0] make_instr(input logic [4:0] op, input logic [2:0] a,
                                             input logic [7:0] low);
    return {op, a, low};
  endfunction

  function automatic logic [27:0] alu_bits(input logic [4:0] op);
    return {op, 23'd0};
  endfunction

  function automatic logic [27:0] ctrl_now();
    return {alu_op, alu_src, reg_write, mem_read, mem_write, ldm, mem_to_reg, branch, pc_sel,
            call, ret, rti, stack, pop_pc1, pop_pc2, pop_ccr, mem_data_sel, port_read,
            port_write, freeze, fetch_pc_enable};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic add_row(input string name, input logic [15:0] instr, input logic intr,
                         input logic lu, input logic [2:0] cc, input logic [27:0] exp);
    row_t row;
    row.name  = name;
    row.instr = instr;
    row.intr  = intr;
    row.lu    = lu;
    row.ccr   = cc;
    row.exp   = exp;
    rows.push_back(row);
  endtask

  task automatic write_and_check(input int idx);
    logic [15:0] value;
    value = 16'($urandom);
    @(negedge clk);
    instruction = make_instr(decode_pkg::op_add, 3'(idx), {3'(idx), 5'd0});
    wb_enable   = 1'b1;
    wb_addr     = 3'(idx);
    wb_data     = value;
    #check_delay;
    // the write lands at the coming edge, so the old word is still visible
    check_value($sformatf("r%0d same-cycle op1", idx), 32'(model[idx]), 32'(op1));
    @(negedge clk);
    wb_enable  = 1'b0;
    model[idx] = value;
    #check_delay;
    check_value($sformatf("r%0d op1", idx), 32'(model[idx]), 32'(op1));
    check_value($sformatf("r%0d op2_reg", idx), 32'(model[idx]), 32'(op2_reg));
  endtask

  task automatic build_table();
    string jname [4];
    logic [3:0] cond;
    jname = '{"jz", "jn", "jc", "jmp"};
    add_row("nop", make_instr(decode_pkg::op_nop, 3'd0, 8'h00), 0, 0, 0, fetch_en);
    add_row("mov", make_instr(decode_pkg::op_mov, 3'd1, 8'h4a), 0, 0, 0,
            alu_bits(decode_pkg::op_mov) | reg_wr | fetch_en);
    add_row("add", make_instr(decode_pkg::op_add, 3'd2, 8'h6c), 0, 0, 0,
            alu_bits(decode_pkg::op_add) | reg_wr | fetch_en);
    add_row("sub", make_instr(decode_pkg::op_sub, 3'd3, 8'h81), 0, 0, 0,
            alu_bits(decode_pkg::op_sub) | reg_wr | fetch_en);
    add_row("and", make_instr(decode_pkg::op_and, 3'd4, 8'ha3), 0, 0, 0,
            alu_bits(decode_pkg::op_and) | reg_wr | fetch_en);
    add_row("or", make_instr(decode_pkg::op_or, 3'd5, 8'hc5), 0, 0, 0,
            alu_bits(decode_pkg::op_or) | reg_wr | fetch_en);
    add_row("not", make_instr(decode_pkg::op_not, 3'd6, 8'he0), 0, 0, 0,
            alu_bits(decode_pkg::op_not) | reg_wr | fetch_en);
    add_row("shl", make_instr(decode_pkg::op_shl, 3'd7, 8'h05), 0, 0, 0,
            alu_bits(decode_pkg::op_shl) | src_imm | reg_wr | fetch_en);
    add_row("shr", make_instr(decode_pkg::op_shr, 3'd2, 8'h0b), 0, 0, 0,
            alu_bits(decode_pkg::op_shr) | src_imm | reg_wr | fetch_en);
    add_row("ldm", make_instr(decode_pkg::op_ldm, 3'd6, 8'h9e), 0, 0, 0,
            src_imm | ldm_bit | reg_wr | fetch_en);
    add_row("ldd", make_instr(decode_pkg::op_ldd, 3'd1, 8'h3f), 0, 0, 0,
            mem_rd | to_reg | reg_wr | fetch_en);
    add_row("std", make_instr(decode_pkg::op_std, 3'd3, 8'h52), 0, 0, 0, mem_wr | fetch_en);
    add_row("push", make_instr(decode_pkg::op_push, 3'd4, 8'h77), 0, 0, 0,
            mem_wr | stk_bit | fetch_en);
    add_row("pop", make_instr(decode_pkg::op_pop, 3'd5, 8'hd8), 0, 0, 0,
            mem_rd | stk_bit | to_reg | reg_wr | fetch_en);
    add_row("in", make_instr(decode_pkg::op_in, 3'd0, 8'hf1), 0, 0, 0,
            prt_rd | reg_wr | fetch_en);
    add_row("out", make_instr(decode_pkg::op_out, 3'd7, 8'h29), 0, 0, 0, prt_wr | fetch_en);
    add_row("call", make_instr(decode_pkg::op_call, 3'd2, 8'hb4), 0, 0, 3'd1,
            br_bit | pc_jump | call_bit | stk_bit | fetch_en);
    for (int j = 0; j < 4; j++) begin
      for (int c = 0; c < 8; c++) begin
        cond = {1'b1, 3'(c)};  // jmp always jumps
        add_row($sformatf("%s ccr=%0d", jname[j], c),
                make_instr(5'(decode_pkg::op_jz + j), 3'd1, {3'(c + 2), 5'd9}), 0, 0, 3'(c),
                br_bit | (cond[j] ? pc_jump : 28'd0) | fetch_en);
      end
    end
    add_row("bubble add", make_instr(decode_pkg::op_add, 3'd1, 8'h40), 0, 1, 0, 28'd0);
    add_row("bubble jmp", make_instr(decode_pkg::op_jmp, 3'd3, 8'h60), 0, 1, 0, 28'd0);
    add_row("bubble interrupt", make_instr(decode_pkg::op_nop, 3'd0, 8'h00), 1, 1, 0, 28'd0);
    add_row("bubble rti", make_instr(decode_pkg::op_rti, 3'd0, 8'h00), 0, 1, 0, 28'd0);
  endtask

  task automatic apply_row(input row_t row);
    logic [2:0] rs1;
    logic [2:0] rs2;
    logic [3:0] cond;
    logic       tk;
    @(negedge clk);
    instruction = row.instr;
    interrupt   = row.intr;
    load_use    = row.lu;
    ccr         = row.ccr;
    #check_delay;
    rs1  = row.instr[10:8];
    rs2  = row.instr[7:5];
    cond = {1'b1, row.ccr};
    tk   = row.exp[15] & cond[row.instr[12:11]];
    check_value({row.name, " control"}, 32'(row.exp), 32'(ctrl_now()));
    check_value({row.name, " taken"}, 32'(tk), 32'(UUT.taken));
    check_value({row.name, " dest_addr"}, 32'(row.exp[21] ? rs1 : rs2), 32'(dest_addr));
    check_value({row.name, " op2_imm"}, 32'(row.instr[7:0]), 32'(op2_imm));
    check_value({row.name, " shift_amount"}, 32'(row.instr[7:0]), 32'(shift_amount));
    check_value({row.name, " op1"}, 32'(model[rs1]), 32'(op1));
    check_value({row.name, " op2_reg"}, 32'(model[rs2]), 32'(op2_reg));
    check_value({row.name, " jump_target"}, 32'(model[rs2]), jump_target);
  endtask

  // steps through a stack sequence until freeze drops while load_use may stay high after
  // the first cycle
  task automatic run_sequence(input string name, input logic [15:0] instr, input logic intr,
                              input logic hold_lu);
    int          n;
    logic        done;
    logic [27:0] expected;
    n    = 0;
    done = 1'b0;
    @(negedge clk);
    instruction = instr;
    interrupt   = intr;
    load_use    = 1'b0;
    while (!done) begin
      #check_delay;
      expected = (n < seq_exp.size()) ? seq_exp[n] : 28'd0;
      check_value($sformatf("%s cycle %0d", name, n), 32'(expected), 32'(ctrl_now()));
      n++;
      done = !freeze;
      if (!done) begin
        if (n >= seq_timeout) begin
          abort_run($sformatf("%s never released freeze", name));
        end
        @(negedge clk);
        interrupt = 1'b0;
        load_use  = hold_lu;
      end
    end
    @(negedge clk);
    instruction = make_instr(decode_pkg::op_nop, 3'd0, 8'h00);
    interrupt   = 1'b0;
    load_use    = 1'b0;
    #check_delay;
    check_value({name, " back to decode"}, 32'(fetch_en), 32'(ctrl_now()));
  endtask

  initial begin
    void'($urandom(32'haf26_8b87));
    arst_n      = 1'b0;
    instruction = '0;
    interrupt   = 1'b0;
    load_use    = 1'b0;
    ccr         = '0;
    wb_enable   = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    for (int i = 0; i < 8; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int i = 0; i < 8; i++) begin
      write_and_check(i);
    end

    build_table();
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    seq_exp.delete();
    seq_exp.push_back(mem_wr | call_bit | stk_bit | frz_bit);
    seq_exp.push_back(mem_wr | stk_bit | sel_ccr | fetch_en);
    run_sequence("interrupt", make_instr(decode_pkg::op_nop, 3'd0, 8'h00), 1'b1, 1'b0);

    seq_exp.delete();
    seq_exp.push_back(mem_rd | ret_bit | stk_bit | pc1_bit | frz_bit);
    seq_exp.push_back(mem_rd | ret_bit | stk_bit | pc2_bit | fetch_en);
    run_sequence("ret", make_instr(decode_pkg::op_ret, 3'd0, 8'h00), 1'b0, 1'b0);

    seq_exp.delete();
    seq_exp.push_back(mem_rd | rti_bit | stk_bit | pc1_bit | frz_bit);
    seq_exp.push_back(mem_rd | rti_bit | stk_bit | pc2_bit | frz_bit);
    seq_exp.push_back(mem_rd | rti_bit | stk_bit | ccr_bit | fetch_en);
    run_sequence("rti", make_instr(decode_pkg::op_rti, 3'd0, 8'h00), 1'b0, 1'b1);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: verilog.f
common/decode_pkg.sv
common/reg_read_if.sv
register_file/register_file.sv
control_unit/control_unit.sv
source/branch_unit.sv
source/instruction_decode.sv
verification/tb_instruction_decode.sv
